/* rtl/issue_pkg.sv */
`default_nettype none

package issue_pkg;

    localparam int DATA_W    = 32;
    localparam int TAG_W     = 7;                   // 128 physical registers
    localparam int RS_DEPTH  = 16;
    localparam int MEM_WORDS = 64;
    localparam int MEM_AW    = $clog2(MEM_WORDS);  // word index width

    typedef enum logic [2:0] {
        OP_ADD   = 3'd0,
        OP_SUB   = 3'd1,
        OP_AND   = 3'd2,
        OP_OR    = 3'd3,
        OP_XOR   = 3'd4,
        OP_SLT   = 3'd5,  // signed, result 1 or 0
        OP_LOAD  = 3'd6,
        OP_STORE = 3'd7
    } op_t;

    // true for anything the integer ALU executes
    function automatic logic is_alu_op(input op_t op);
        case (op)
            OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR, OP_SLT:
                return 1'b1;
            default:
                return 1'b0;
        endcase
    endfunction

    // loads and stores go to the memory unit
    function automatic logic is_mem_op(input op_t op);
        return (op == OP_LOAD) || (op == OP_STORE);
    endfunction

endpackage

`default_nettype wire

/* rtl/issue_select.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_select #(
    parameter int WIDTH = 16
) (
    input  wire [WIDTH-1:0] request,
    output logic [WIDTH-1:0] grant,
    output logic             found
);

    // lowest set request wins
    always_comb begin
        grant = '0;
        for (int i = 0; i < WIDTH; i++) begin
            if (request[i] && (grant == '0))
                grant[i] = 1'b1;
        end
    end

    assign found = |request;  // saves the caller a zero test

endmodule

`default_nettype wire

/* rtl/reservation_station.sv */
`timescale 1ns/1ps
`default_nettype none

module reservation_station (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               dispatch_valid,
    input  wire issue_pkg::op_t               dispatch_op,
    input  wire [issue_pkg::TAG_W-1:0]        dispatch_dest,
    input  wire [issue_pkg::TAG_W-1:0]        dispatch_src1_tag,
    input  wire [issue_pkg::DATA_W-1:0]       dispatch_src1_value,
    input  wire                               dispatch_src1_ok,
    input  wire [issue_pkg::TAG_W-1:0]        dispatch_src2_tag,
    input  wire [issue_pkg::DATA_W-1:0]       dispatch_src2_value,
    input  wire                               dispatch_src2_ok,
    input  wire [issue_pkg::DATA_W-1:0]       dispatch_imm,
    output logic                              dispatch_ready,
    input  wire                               alu_wb_valid,
    input  wire [issue_pkg::TAG_W-1:0]        alu_wb_tag,
    input  wire [issue_pkg::DATA_W-1:0]       alu_wb_value,
    input  wire                               load_wb_valid,
    input  wire [issue_pkg::TAG_W-1:0]        load_wb_tag,
    input  wire [issue_pkg::DATA_W-1:0]       load_wb_value,
    output logic                              issue_valid,
    output issue_pkg::op_t                    issue_op,
    output logic [issue_pkg::TAG_W-1:0]       issue_dest,
    output logic [issue_pkg::DATA_W-1:0]      issue_a,
    output logic [issue_pkg::DATA_W-1:0]      issue_b,
    output logic [issue_pkg::DATA_W-1:0]      issue_imm
);

    localparam int N = issue_pkg::RS_DEPTH;

    // entry storage
    logic [N-1:0]                   busy;
    logic [N-1:0]                   ent_ok1;
    logic [N-1:0]                   ent_ok2;
    issue_pkg::op_t                 ent_op   [N];
    logic [issue_pkg::TAG_W-1:0]    ent_dest [N];
    logic [issue_pkg::DATA_W-1:0]   ent_imm  [N];
    logic [issue_pkg::TAG_W-1:0]    ent_tag1 [N];
    logic [issue_pkg::TAG_W-1:0]    ent_tag2 [N];
    logic [issue_pkg::DATA_W-1:0]   ent_val1 [N];
    logic [issue_pkg::DATA_W-1:0]   ent_val2 [N];

    // operands as seen this cycle, broadcasts included
    logic [N-1:0]                   cur_ok1;
    logic [N-1:0]                   cur_ok2;
    logic [issue_pkg::DATA_W-1:0]   cur_val1 [N];
    logic [issue_pkg::DATA_W-1:0]   cur_val2 [N];
    logic [N-1:0]                   ready_vec;

    logic                           byp_ok1;
    logic                           byp_ok2;
    logic [issue_pkg::DATA_W-1:0]   byp_val1;
    logic [issue_pkg::DATA_W-1:0]   byp_val2;

    logic [N-1:0]                   alloc_grant;
    logic                           alloc_found;
    logic [N-1:0]                   issue_grant;
    logic                           issue_found;
    logic                           dispatch_fire;

    issue_pkg::op_t                 sel_op;
    logic [issue_pkg::TAG_W-1:0]    sel_dest;
    logic [issue_pkg::DATA_W-1:0]   sel_a;
    logic [issue_pkg::DATA_W-1:0]   sel_b;
    logic [issue_pkg::DATA_W-1:0]   sel_imm;

    // {present, value} after looking at both buses, alu bus first
    function automatic logic [issue_pkg::DATA_W:0] snoop(
        input logic                          ok,
        input logic [issue_pkg::TAG_W-1:0]   tag,
        input logic [issue_pkg::DATA_W-1:0]  value
    );
        if (ok)
            return {1'b1, value};
        else if (alu_wb_valid && (alu_wb_tag == tag))
            return {1'b1, alu_wb_value};
        else if (load_wb_valid && (load_wb_tag == tag))
            return {1'b1, load_wb_value};
        else
            return {1'b0, value};
    endfunction

    always_comb begin
        for (int i = 0; i < N; i++) begin
            {cur_ok1[i], cur_val1[i]} = snoop(ent_ok1[i], ent_tag1[i], ent_val1[i]);
            {cur_ok2[i], cur_val2[i]} = snoop(ent_ok2[i], ent_tag2[i], ent_val2[i]);
            ready_vec[i] = busy[i] && cur_ok1[i] && cur_ok2[i];
        end
        // same-cycle bypass for incoming sources
        {byp_ok1, byp_val1} = snoop(dispatch_src1_ok, dispatch_src1_tag, dispatch_src1_value);
        {byp_ok2, byp_val2} = snoop(dispatch_src2_ok, dispatch_src2_tag, dispatch_src2_value);
    end

    issue_select #(
        .WIDTH (N)
    ) i_alloc_select (
        .request (~busy),
        .grant   (alloc_grant),
        .found   (alloc_found)
    );

    issue_select #(
        .WIDTH (N)
    ) i_issue_select (
        .request (ready_vec),
        .grant   (issue_grant),
        .found   (issue_found)
    );

    assign dispatch_ready = alloc_found;
    assign dispatch_fire  = dispatch_valid && dispatch_ready;

    // one-hot mux of the granted entry
    always_comb begin
        sel_op   = issue_pkg::OP_ADD;
        sel_dest = '0;
        sel_a    = '0;
        sel_b    = '0;
        sel_imm  = '0;
        for (int i = 0; i < N; i++) begin
            if (issue_grant[i]) begin
                sel_op   = ent_op[i];
                sel_dest = ent_dest[i];
                sel_a    = cur_val1[i];
                sel_b    = cur_val2[i];
                sel_imm  = ent_imm[i];
            end
        end
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            busy        <= '0;
            ent_ok1     <= '0;
            ent_ok2     <= '0;
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= issue_found;
            for (int i = 0; i < N; i++) begin
                if (dispatch_fire && alloc_grant[i]) begin
                    busy[i]    <= 1'b1;
                    ent_ok1[i] <= byp_ok1;
                    ent_ok2[i] <= byp_ok2;
                end else begin
                    if (issue_grant[i])
                        busy[i] <= 1'b0;  // freed as it issues
                    ent_ok1[i] <= cur_ok1[i] && busy[i];
                    ent_ok2[i] <= cur_ok2[i] && busy[i];
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        for (int i = 0; i < N; i++) begin
            if (dispatch_fire && alloc_grant[i]) begin
                ent_op[i]   <= dispatch_op;
                ent_dest[i] <= dispatch_dest;
                ent_imm[i]  <= dispatch_imm;
                ent_tag1[i] <= dispatch_src1_tag;
                ent_tag2[i] <= dispatch_src2_tag;
                ent_val1[i] <= byp_val1;
                ent_val2[i] <= byp_val2;
            end else begin
                ent_val1[i] <= cur_val1[i];  // wakeup capture
                ent_val2[i] <= cur_val2[i];
            end
        end
        if (issue_found) begin
            issue_op   <= sel_op;
            issue_dest <= sel_dest;
            issue_a    <= sel_a;
            issue_b    <= sel_b;
            issue_imm  <= sel_imm;
        end
    end

endmodule

`default_nettype wire

/* rtl/int_alu.sv */
`timescale 1ns/1ps
`default_nettype none

module int_alu (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               issue_valid,
    input  wire issue_pkg::op_t               issue_op,
    input  wire [issue_pkg::TAG_W-1:0]        issue_dest,
    input  wire [issue_pkg::DATA_W-1:0]       issue_a,
    input  wire [issue_pkg::DATA_W-1:0]       issue_b,
    output logic                              alu_wb_valid,
    output logic [issue_pkg::TAG_W-1:0]       alu_wb_tag,
    output logic [issue_pkg::DATA_W-1:0]      alu_wb_value
);

    logic                           accept;
    logic                           less;
    logic [issue_pkg::DATA_W-1:0]   result;

    assign accept = issue_valid && issue_pkg::is_alu_op(issue_op);
    assign less   = $signed(issue_a) < $signed(issue_b);

    always_comb begin
        case (issue_op)
            issue_pkg::OP_ADD:
                result = issue_a + issue_b;
            issue_pkg::OP_SUB:
                result = issue_a - issue_b;
            issue_pkg::OP_AND:
                result = issue_a & issue_b;
            issue_pkg::OP_OR:
                result = issue_a | issue_b;
            issue_pkg::OP_XOR:
                result = issue_a ^ issue_b;
            issue_pkg::OP_SLT:
                result = {{(issue_pkg::DATA_W-1){1'b0}}, less};
            default:
                result = '0;  // load/store handled elsewhere
        endcase
    end

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            alu_wb_valid <= 1'b0;
        end else begin
            alu_wb_valid <= accept;
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            alu_wb_tag   <= issue_dest;
            alu_wb_value <= result;
        end
    end

endmodule

`default_nettype wire

/* rtl/load_store_unit.sv */
`timescale 1ns/1ps
`default_nettype none

module load_store_unit (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               issue_valid,
    input  wire issue_pkg::op_t               issue_op,
    input  wire [issue_pkg::TAG_W-1:0]        issue_dest,
    input  wire [issue_pkg::DATA_W-1:0]       issue_a,
    input  wire [issue_pkg::DATA_W-1:0]       issue_b,
    input  wire [issue_pkg::DATA_W-1:0]       issue_imm,
    output logic                              load_wb_valid,
    output logic [issue_pkg::TAG_W-1:0]       load_wb_tag,
    output logic [issue_pkg::DATA_W-1:0]      load_wb_value
);

    logic [issue_pkg::DATA_W-1:0]   mem [issue_pkg::MEM_WORDS];
    logic [issue_pkg::DATA_W-1:0]   addr_sum;
    logic [issue_pkg::MEM_AW-1:0]   addr;
    logic                           is_load;
    logic                           is_store;

    assign addr_sum = issue_a + issue_imm;                // base plus offset
    assign addr     = addr_sum[issue_pkg::MEM_AW-1:0];    // wraps at MEM_WORDS
    assign is_load  = issue_valid && (issue_op == issue_pkg::OP_LOAD);
    assign is_store = issue_valid && (issue_op == issue_pkg::OP_STORE);

    always_ff @(posedge clk or posedge reset) begin
        if (reset) begin
            load_wb_valid <= 1'b0;
            for (int i = 0; i < issue_pkg::MEM_WORDS; i++)
                mem[i] <= '0;
        end else begin
            load_wb_valid <= is_load;
            if (is_store)
                mem[addr] <= issue_b;  // no broadcast for stores
        end
    end

    always_ff @(posedge clk) begin
        if (is_load) begin
            load_wb_tag   <= issue_dest;
            load_wb_value <= mem[addr];
        end
    end

endmodule

`default_nettype wire

/* rtl/issue_core.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_core (
    input  wire                               clk,
    input  wire                               reset,
    input  wire                               dispatch_valid,
    input  wire issue_pkg::op_t               dispatch_op,
    input  wire [issue_pkg::TAG_W-1:0]        dispatch_dest,
    input  wire [issue_pkg::TAG_W-1:0]        dispatch_src1_tag,
    input  wire [issue_pkg::DATA_W-1:0]       dispatch_src1_value,
    input  wire                               dispatch_src1_ok,
    input  wire [issue_pkg::TAG_W-1:0]        dispatch_src2_tag,
    input  wire [issue_pkg::DATA_W-1:0]       dispatch_src2_value,
    input  wire                               dispatch_src2_ok,
    input  wire [issue_pkg::DATA_W-1:0]       dispatch_imm,
    output wire                               dispatch_ready,
    output wire                               alu_wb_valid,
    output wire [issue_pkg::TAG_W-1:0]        alu_wb_tag,
    output wire [issue_pkg::DATA_W-1:0]       alu_wb_value,
    output wire                               load_wb_valid,
    output wire [issue_pkg::TAG_W-1:0]        load_wb_tag,
    output wire [issue_pkg::DATA_W-1:0]       load_wb_value
);

    // station to units
    wire                            issue_valid;
    issue_pkg::op_t                 issue_op;
    wire [issue_pkg::TAG_W-1:0]     issue_dest;
    wire [issue_pkg::DATA_W-1:0]    issue_a;
    wire [issue_pkg::DATA_W-1:0]    issue_b;
    wire [issue_pkg::DATA_W-1:0]    issue_imm;

    reservation_station i_reservation_station (
        .clk                 (clk),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_dest       (dispatch_dest),
        .dispatch_src1_tag   (dispatch_src1_tag),
        .dispatch_src1_value (dispatch_src1_value),
        .dispatch_src1_ok    (dispatch_src1_ok),
        .dispatch_src2_tag   (dispatch_src2_tag),
        .dispatch_src2_value (dispatch_src2_value),
        .dispatch_src2_ok    (dispatch_src2_ok),
        .dispatch_imm        (dispatch_imm),
        .dispatch_ready      (dispatch_ready),
        .alu_wb_valid        (alu_wb_valid),
        .alu_wb_tag          (alu_wb_tag),
        .alu_wb_value        (alu_wb_value),
        .load_wb_valid       (load_wb_valid),
        .load_wb_tag         (load_wb_tag),
        .load_wb_value       (load_wb_value),
        .issue_valid         (issue_valid),
        .issue_op            (issue_op),
        .issue_dest          (issue_dest),
        .issue_a             (issue_a),
        .issue_b             (issue_b),
        .issue_imm           (issue_imm)
    );

    int_alu i_int_alu (
        .clk          (clk),
        .reset        (reset),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_dest   (issue_dest),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .alu_wb_valid (alu_wb_valid),
        .alu_wb_tag   (alu_wb_tag),
        .alu_wb_value (alu_wb_value)
    );

    load_store_unit i_load_store_unit (
        .clk           (clk),
        .reset         (reset),
        .issue_valid   (issue_valid),
        .issue_op      (issue_op),
        .issue_dest    (issue_dest),
        .issue_a       (issue_a),
        .issue_b       (issue_b),
        .issue_imm     (issue_imm),
        .load_wb_valid (load_wb_valid),
        .load_wb_tag   (load_wb_tag),
        .load_wb_value (load_wb_value)
    );

endmodule

`default_nettype wire

/* verif/issue_core_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_core_checker (
    input  wire                              clk,
    input  wire                              reset,
    input  wire                              issue_valid,
    input  wire [issue_pkg::RS_DEPTH-1:0]    grant,
    input  wire [issue_pkg::RS_DEPTH-1:0]    busy,
    input  wire                              dispatch_ready,
    input  wire                              alu_wb_valid,
    input  wire [issue_pkg::TAG_W-1:0]       alu_wb_tag,
    input  wire                              load_wb_valid,
    input  wire [issue_pkg::TAG_W-1:0]       load_wb_tag
);

    // issue register was loaded from exactly one entry
    assert property (@(posedge clk) disable iff (reset)
        issue_valid |-> $onehot($past(grant)))
        else $error("issue without a one-hot grant");

    assert property (@(posedge clk) disable iff (reset)
        (!dispatch_ready) == (&busy))
        else $error("dispatch_ready does not match a full station");

    assert property (@(posedge clk) disable iff (reset)
        alu_wb_valid |-> !$isunknown(alu_wb_tag))
        else $error("unknown tag on the ALU bus");

    assert property (@(posedge clk) disable iff (reset)
        load_wb_valid |-> !$isunknown(load_wb_tag))
        else $error("unknown tag on the load bus");

endmodule

bind reservation_station issue_core_checker i_issue_core_checker (
    .clk            (clk),
    .reset          (reset),
    .issue_valid    (issue_valid),
    .grant          (issue_grant),
    .busy           (busy),
    .dispatch_ready (dispatch_ready),
    .alu_wb_valid   (alu_wb_valid),
    .alu_wb_tag     (alu_wb_tag),
    .load_wb_valid  (load_wb_valid),
    .load_wb_tag    (load_wb_tag)
);

`default_nettype wire

/* verif/issue_core_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module issue_core_tb;

    localparam int MAX_ROWS  = 32;
    localparam int FILL_ROWS = 17;
    localparam logic [6:0] NEVER_TAG = 7'd127;  // no row ever produces it

    logic        clk;
    logic        reset;
    logic        dispatch_valid;
    issue_pkg::op_t dispatch_op;
    logic [6:0]  dispatch_dest;
    logic [6:0]  dispatch_src1_tag;
    logic [31:0] dispatch_src1_value;
    logic        dispatch_src1_ok;
    logic [6:0]  dispatch_src2_tag;
    logic [31:0] dispatch_src2_value;
    logic        dispatch_src2_ok;
    logic [31:0] dispatch_imm;
    wire         dispatch_ready;
    wire         alu_wb_valid;
    wire  [6:0]  alu_wb_tag;
    wire  [31:0] alu_wb_value;
    wire         load_wb_valid;
    wire  [6:0]  load_wb_tag;
    wire  [31:0] load_wb_value;

    // stimulus table
    string          t_name  [MAX_ROWS];
    issue_pkg::op_t t_op    [MAX_ROWS];
    logic [6:0]     t_dest  [MAX_ROWS];
    logic [6:0]     t_tag1  [MAX_ROWS];
    logic [31:0]    t_val1  [MAX_ROWS];
    bit             t_ok1   [MAX_ROWS];
    logic [6:0]     t_tag2  [MAX_ROWS];
    logic [31:0]    t_val2  [MAX_ROWS];
    bit             t_ok2   [MAX_ROWS];
    logic [31:0]    t_imm   [MAX_ROWS];
    bit             t_iso   [MAX_ROWS];  // check 2 cycle latency
    bit             t_byp   [MAX_ROWS];  // producer must be on the bus at dispatch
    bit             t_drain [MAX_ROWS];
    int             n_rows;

    // scoreboard by tag
    logic [31:0] exp_val    [128];
    bit          pending    [128];
    bit          done       [128];
    bit          chk_lat    [128];
    int          accept_cyc [128];
    int          bcast_cyc  [128];
    bit          dep_on1    [128];
    bit          dep_on2    [128];
    logic [6:0]  dep_tag1   [128];
    logic [6:0]  dep_tag2   [128];
    string       test_of    [128];
    logic [31:0] model_mem  [64];

    integer seed = 32'hf4a0_a33b;
    int     cycle = 0;
    int     limit;
    int     errors = 0;
    int     checks = 0;
    int     tests = 0;

    issue_core i_issue_core (
        .clk                 (clk),
        .reset               (reset),
        .dispatch_valid      (dispatch_valid),
        .dispatch_op         (dispatch_op),
        .dispatch_dest       (dispatch_dest),
        .dispatch_src1_tag   (dispatch_src1_tag),
        .dispatch_src1_value (dispatch_src1_value),
        .dispatch_src1_ok    (dispatch_src1_ok),
        .dispatch_src2_tag   (dispatch_src2_tag),
        .dispatch_src2_value (dispatch_src2_value),
        .dispatch_src2_ok    (dispatch_src2_ok),
        .dispatch_imm        (dispatch_imm),
        .dispatch_ready      (dispatch_ready),
        .alu_wb_valid        (alu_wb_valid),
        .alu_wb_tag          (alu_wb_tag),
        .alu_wb_value        (alu_wb_value),
        .load_wb_valid       (load_wb_valid),
        .load_wb_tag         (load_wb_tag),
        .load_wb_value       (load_wb_value)
    );

    initial begin
        clk = 1'b0;
        forever #10 clk = ~clk;
    end

    always @(posedge clk) begin
        cycle <= cycle + 1;
        if (cycle >= limit) begin
            $display("Error: timeout after %0d cycles with work still outstanding", cycle);
            $display("Simulation finished: FAIL");
            $finish;
        end
    end

    function automatic logic [31:0] model_alu(issue_pkg::op_t op, logic [31:0] a,
                                              logic [31:0] b);
        case (op)
            issue_pkg::OP_ADD: return a + b;
            issue_pkg::OP_SUB: return a - b;
            issue_pkg::OP_AND: return a & b;
            issue_pkg::OP_OR:  return a | b;
            issue_pkg::OP_XOR: return a ^ b;
            issue_pkg::OP_SLT: return ($signed(a) < $signed(b)) ? 32'd1 : 32'd0;
            default:           return 32'd0;
        endcase
    endfunction

    function automatic int pending_count();
        int n;
        n = 0;
        for (int i = 0; i < 128; i++)
            if (pending[i])
                n++;
        return n;
    endfunction

    task automatic add_row(string name, issue_pkg::op_t op, logic [6:0] dest,
                           logic [6:0] tag1, logic [31:0] val1, bit ok1,
                           logic [6:0] tag2, logic [31:0] val2, bit ok2,
                           logic [31:0] imm, bit iso, bit byp, bit drain);
        t_name[n_rows] = name;
        t_op[n_rows]   = op;
        t_dest[n_rows] = dest;
        t_tag1[n_rows] = tag1;
        t_val1[n_rows] = val1;
        t_ok1[n_rows]  = ok1;
        t_tag2[n_rows] = tag2;
        t_val2[n_rows] = val2;
        t_ok2[n_rows]  = ok2;
        t_imm[n_rows]  = imm;
        t_iso[n_rows]  = iso;
        t_byp[n_rows]  = byp;
        t_drain[n_rows] = drain;
        n_rows++;
    endtask

    task automatic build_table();
        n_rows = 0;
        for (int k = 0; k < 6; k++)
            add_row("alu_ops", issue_pkg::op_t'(k[2:0]), 7'(k + 1), 7'd0, $random(seed), 1'b1,
                    7'd0, $random(seed), 1'b1, 32'd0, 1'b1, 1'b0, 1'b1);
        // chain 10 -> 11 -> 12 -> 13
        add_row("dep_chain", issue_pkg::OP_ADD, 7'd10, 7'd0, $random(seed), 1'b1,
                7'd0, $random(seed), 1'b1, 32'd0, 1'b0, 1'b0, 1'b0);
        add_row("dep_chain", issue_pkg::OP_SUB, 7'd11, 7'd10, 32'd0, 1'b0,
                7'd0, $random(seed), 1'b1, 32'd0, 1'b0, 1'b0, 1'b0);
        add_row("dep_chain", issue_pkg::OP_SLT, 7'd12, 7'd11, 32'd0, 1'b0,
                7'd10, 32'd0, 1'b0, 32'd0, 1'b0, 1'b0, 1'b0);
        add_row("dep_chain", issue_pkg::OP_XOR, 7'd13, 7'd12, 32'd0, 1'b0,
                7'd11, 32'd0, 1'b0, 32'd0, 1'b0, 1'b0, 1'b1);
        // consumer lands on the edge after the producer broadcast
        add_row("bypass", issue_pkg::OP_ADD, 7'd20, 7'd0, $random(seed), 1'b1,
                7'd0, $random(seed), 1'b1, 32'd0, 1'b0, 1'b0, 1'b0);
        add_row("bypass", issue_pkg::OP_OR, 7'd21, 7'd0, $random(seed), 1'b1,
                7'd0, $random(seed), 1'b1, 32'd0, 1'b0, 1'b0, 1'b0);
        add_row("bypass", issue_pkg::OP_AND, 7'd22, 7'd0, $random(seed), 1'b1,
                7'd0, $random(seed), 1'b1, 32'd0, 1'b0, 1'b0, 1'b0);
        add_row("bypass", issue_pkg::OP_XOR, 7'd23, 7'd20, 32'd0, 1'b0,
                7'd0, $random(seed), 1'b1, 32'd0, 1'b0, 1'b1, 1'b1);
        add_row("store_load", issue_pkg::OP_STORE, 7'd0, 7'd0, 32'd8, 1'b1,
                7'd0, $random(seed), 1'b1, 32'd2, 1'b0, 1'b0, 1'b0);
        add_row("store_load", issue_pkg::OP_STORE, 7'd0, 7'd0, 32'd30, 1'b1,
                7'd0, $random(seed), 1'b1, 32'd5, 1'b0, 1'b0, 1'b0);
        add_row("store_load", issue_pkg::OP_STORE, 7'd0, 7'd0, 32'd60, 1'b1,
                7'd0, $random(seed), 1'b1, 32'd7, 1'b0, 1'b0, 1'b1);  // wraps to 3
        add_row("store_load", issue_pkg::OP_LOAD, 7'd30, 7'd0, 32'd4, 1'b1,
                7'd0, 32'd0, 1'b1, 32'd6, 1'b0, 1'b0, 1'b0);
        add_row("store_load", issue_pkg::OP_LOAD, 7'd31, 7'd0, 32'd35, 1'b1,
                7'd0, 32'd0, 1'b1, 32'd0, 1'b0, 1'b0, 1'b0);
        add_row("store_load", issue_pkg::OP_LOAD, 7'd32, 7'd0, 32'd1, 1'b1,
                7'd0, 32'd0, 1'b1, 32'd2, 1'b0, 1'b0, 1'b0);
        add_row("store_load", issue_pkg::OP_LOAD, 7'd33, 7'd0, 32'd50, 1'b1,
                7'd0, 32'd0, 1'b1, 32'd0, 1'b0, 1'b0, 1'b1);  // never written
    endtask

    // runs from posedge + 2 ns to 2 ns after the accepting edge
    task automatic send_row(int r);
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sum;
        logic [6:0]  d;
        bit          taken;
        d   = t_dest[r];
        a   = t_ok1[r] ? t_val1[r] : exp_val[t_tag1[r]];
        b   = t_ok2[r] ? t_val2[r] : exp_val[t_tag2[r]];
        sum = a + t_imm[r];
        if (t_op[r] == issue_pkg::OP_STORE) begin
            model_mem[sum[5:0]] = b;
        end else begin
            if (t_op[r] == issue_pkg::OP_LOAD)
                exp_val[d] = model_mem[sum[5:0]];
            else
                exp_val[d] = model_alu(t_op[r], a, b);
            pending[d]  = 1'b1;
            done[d]     = 1'b0;
            chk_lat[d]  = t_iso[r];
            dep_on1[d]  = !t_ok1[r];
            dep_on2[d]  = !t_ok2[r];
            dep_tag1[d] = t_tag1[r];
            dep_tag2[d] = t_tag2[r];
            test_of[d]  = t_name[r];
        end
        dispatch_op         = t_op[r];
        dispatch_dest       = d;
        dispatch_src1_tag   = t_tag1[r];
        dispatch_src1_value = t_val1[r];
        dispatch_src1_ok    = t_ok1[r];
        dispatch_src2_tag   = t_tag2[r];
        dispatch_src2_value = t_val2[r];
        dispatch_src2_ok    = t_ok2[r];
        dispatch_imm        = t_imm[r];
        dispatch_valid      = 1'b1;
        taken = 1'b0;
        while (!taken) begin
            @(negedge clk);
            if (dispatch_ready) begin
                taken = 1'b1;
                accept_cyc[d] = cycle + 1;
                if (t_byp[r] && !(alu_wb_valid && alu_wb_tag == t_tag1[r])) begin
                    $display("Error: test %s producer tag %0d was not on the ALU bus at dispatch",
                             t_name[r], t_tag1[r]);
                    errors++;
                end
            end
            @(posedge clk);
        end
        #2;
        dispatch_valid = 1'b0;
    endtask

    // waits for all broadcasts and an empty station plus one edge for a trailing store
    task automatic drain();
        do
            @(negedge clk);
        while (pending_count() != 0 || i_issue_core.i_reservation_station.busy != '0);
        @(posedge clk);
        #2;
    endtask

    task automatic check_bcast(logic [6:0] tag, logic [31:0] value, string bus);
        checks++;
        if (!pending[tag]) begin
            $display("Error: unexpected broadcast on the %s bus with tag %0d", bus, tag);
            errors++;
        end else begin
            if (value !== exp_val[tag]) begin
                $display("Error: test %s tag %0d expected %h actual %h",
                         test_of[tag], tag, exp_val[tag], value);
                errors++;
            end
            if (chk_lat[tag] && (cycle - accept_cyc[tag]) != 2) begin
                $display("Error: test %s tag %0d latency expected 2 actual %0d",
                         test_of[tag], tag, cycle - accept_cyc[tag]);
                errors++;
            end
            if (dep_on1[tag] && !(done[dep_tag1[tag]] && bcast_cyc[dep_tag1[tag]] < cycle)) begin
                $display("Error: test %s tag %0d broadcast before its source %0d",
                         test_of[tag], tag, dep_tag1[tag]);
                errors++;
            end
            if (dep_on2[tag] && !(done[dep_tag2[tag]] && bcast_cyc[dep_tag2[tag]] < cycle)) begin
                $display("Error: test %s tag %0d broadcast before its source %0d",
                         test_of[tag], tag, dep_tag2[tag]);
                errors++;
            end
            pending[tag]   = 1'b0;
            done[tag]      = 1'b1;
            bcast_cyc[tag] = cycle;
        end
    endtask

    // bus monitor sampled mid-cycle
    initial begin
        forever begin
            @(negedge clk);
            if (!reset) begin
                if (alu_wb_valid)
                    check_bcast(alu_wb_tag, alu_wb_value, "ALU");
                if (load_wb_valid)
                    check_bcast(load_wb_tag, load_wb_value, "load");
            end
        end
    end

    task automatic fill_test();
        int accepted;
        int start_err;
        int start_chk;
        bit full;
        start_err = errors;
        start_chk = checks;
        accepted  = 0;
        full      = 1'b0;
        dispatch_op       = issue_pkg::OP_ADD;
        dispatch_src1_tag = NEVER_TAG;
        dispatch_src1_ok  = 1'b0;
        dispatch_src2_ok  = 1'b1;
        for (int k = 0; k < FILL_ROWS && !full; k++) begin
            dispatch_dest  = 7'(100 + k);
            dispatch_valid = 1'b1;
            @(negedge clk);
            if (dispatch_ready) begin
                accepted++;
                @(posedge clk);
                #2;
            end else begin
                full = 1'b1;
            end
        end
        checks++;
        if (accepted != 16 || dispatch_ready) begin
            $display("Error: test fill expected 16 acceptances, ready 0 actual %0d, ready %0b",
                     accepted, dispatch_ready);
            errors++;
        end
        @(posedge clk);
        #2;
        dispatch_valid = 1'b0;
        reset = 1'b1;  // only way out of a full station
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        @(negedge clk);
        checks++;
        if (!dispatch_ready || alu_wb_valid || load_wb_valid) begin
            $display("Error: test fill reset expected ready 1, wb_valid 0/0 actual %0b, %0b/%0b",
                     dispatch_ready, alu_wb_valid, load_wb_valid);
            errors++;
        end
        $display("test fill: %0d checks, %0d errors", checks - start_chk, errors - start_err);
        tests++;
    endtask

    initial begin
        int start_err;
        int start_chk;
        reset               = 1'b1;
        dispatch_valid      = 1'b0;
        dispatch_op         = issue_pkg::OP_ADD;
        dispatch_dest       = 7'd0;
        dispatch_src1_tag   = 7'd0;
        dispatch_src1_value = 32'd0;
        dispatch_src1_ok    = 1'b0;
        dispatch_src2_tag   = 7'd0;
        dispatch_src2_value = 32'd0;
        dispatch_src2_ok    = 1'b0;
        dispatch_imm        = 32'd0;
        for (int i = 0; i < 128; i++) begin
            exp_val[i] = 32'd0;
            pending[i] = 1'b0;
            done[i]    = 1'b0;
        end
        for (int i = 0; i < 64; i++)
            model_mem[i] = 32'd0;  // memory clears at reset
        build_table();
        limit = 40 * (n_rows + FILL_ROWS) + 100;
        start_err = 0;
        start_chk = 0;
        repeat (10) @(posedge clk);
        #2;
        reset = 1'b0;
        @(posedge clk);
        #2;
        for (int r = 0; r < n_rows; r++) begin
            if (r == 0 || t_name[r] != t_name[r-1]) begin
                start_err = errors;
                start_chk = checks;
            end
            send_row(r);
            if (t_iso[r] || t_drain[r])
                drain();
            if (r == n_rows - 1 || t_name[r+1] != t_name[r]) begin
                $display("test %s: %0d checks, %0d errors", t_name[r],
                         checks - start_chk, errors - start_err);
                tests++;
            end
        end
        fill_test();
        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("Simulation finished: PASS");
        end else begin
            $display("Simulation finished: FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* verilog.f */
rtl/issue_pkg.sv
rtl/issue_select.sv
rtl/reservation_station.sv
rtl/int_alu.sv
rtl/load_store_unit.sv
rtl/issue_core.sv
verif/issue_core_checker.sv
verif/issue_core_tb.sv

/* Makefile */
SRCS := $(wildcard rtl/*.sv verif/*.sv)

.PHONY: all run clean

all: obj_dir/Vissue_core_tb

obj_dir/Vissue_core_tb: $(SRCS) verilog.f
	verilator --binary --timing --assert --top-module issue_core_tb -f verilog.f

run: obj_dir/Vissue_core_tb
	@out="$$(./obj_dir/Vissue_core_tb)"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation finished: PASS$$"

clean:
	rm -rf obj_dir
